//--- compile.f
+incdir+source
source/rca_pkg.sv
source/slot_fifo.sv
source/fetch_add_unit.sv
source/grid_pr_slot.sv
source/lsq_mem.sv
source/rca_slot_top.sv
bench/rca_slot_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
    -f compile.f \
    --top-module rca_slot_tb \
    -Mdir "$BUILD_DIR" \
    -o rca_slot_sim

"./$BUILD_DIR/rca_slot_sim" | tee "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- bench/rca_slot_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "rca_macros.svh"

module rca_slot_tb;

    import rca_pkg::*;

    localparam int IDX_W           = $clog2(`RCA_MEM_WORDS);
    localparam int MAX_FILL_PAIRS  = 16;
    localparam int RANDOM_PAIRS    = 20;
    localparam int TOTAL_OPS       = 2 + 3 + MAX_FILL_PAIRS + RANDOM_PAIRS;
    localparam int WATCHDOG_CYCLES = 20 * TOTAL_OPS + 200;

    logic  clk = 1'b0;
    logic  reset;
    xlen_t data_in1;
    xlen_t data_in2;
    logic  data_valid_in1;
    logic  data_valid_in2;
    xlen_t data_out;
    logic  data_valid_out;

    xlen_t  shadow [`RCA_MEM_WORDS];   // Expected memory contents
    xlen_t  exp_q [$];                 // Results still owed, oldest first
    xlen_t  monitor_expected;
    integer seed         = 32'h1f72;
    int     error_count  = 0;
    int     result_count = 0;
    int     pass_count   = 0;
    int     fail_count   = 0;
    int     test_errors_start;

    rca_slot_top uut (
        .clk,
        .reset,
        .data_in1,
        .data_in2,
        .data_valid_in1,
        .data_valid_in2,
        .data_out,
        .data_valid_out
    );

    always #5 clk = ~clk;

    // Results are compared in issue order, away from the rising edge
    always @(negedge clk) begin
        if (!reset && data_valid_out) begin
            result_count++;
            if (exp_q.size() == 0) begin
                $display("Unexpected result %h on data_out at %0t", data_out, $time);
                error_count++;
            end else begin
                monitor_expected = exp_q.pop_front();
                if (data_out !== monitor_expected) begin
                    $display("[ERROR] %0t data_out expected %h got %h",
                             $time, monitor_expected, data_out);
                    error_count++;
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One fetch-and-add on the shadow memory
    task automatic model_op(input xlen_t addr, input xlen_t addend);
        xlen_t sum;
        sum = shadow[addr[IDX_W+1:2]] + addend;
        shadow[addr[IDX_W+1:2]] = sum;
        exp_q.push_back(sum);
    endtask

    task automatic drive_inputs(input logic v1, input xlen_t w1,
                                input logic v2, input xlen_t w2);
        data_valid_in1 = v1;
        data_in1       = w1;
        data_valid_in2 = v2;
        data_in2       = w2;
        next_cycle();
        data_valid_in1 = 1'b0;   // Strobes last one cycle
        data_valid_in2 = 1'b0;
    endtask

    task automatic push_pair(input xlen_t addr, input xlen_t addend);
        while (uut.slot.input1_fifo.full || uut.slot.input2_fifo.full) begin
            next_cycle();
        end
        model_op(addr, addend);
        drive_inputs(1'b1, addr, 1'b1, addend);
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        next_cycle();
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
            pass_count++;
            $display("Test %s passed", name);
        end else begin
            fail_count++;
            $display("Test %s failed with %0d errors", name, error_count - test_errors_start);
        end
    endtask

    task automatic test_reset_idle();
        test_errors_start = error_count;
        repeat (10) begin
            @(negedge clk);
            if (data_valid_out !== 1'b0) begin
                $display("[ERROR] %0t data_valid_out expected 0 got %b", $time, data_valid_out);
                error_count++;
            end
        end
        next_cycle();
        end_test("reset_idle");
    endtask

    // Second result only matches if the first sum was stored back
    task automatic test_single_op();
        test_errors_start = error_count;
        push_pair(32'h10, 32'h0000_1234);
        wait_results();
        push_pair(32'h10, 32'h0000_0f0f);
        wait_results();
        end_test("single_op");
    endtask

    task automatic test_uneven_rates();
        xlen_t addrs [3];
        xlen_t addends [3];
        test_errors_start = error_count;
        addrs[0]   = 32'h40;
        addrs[1]   = 32'h44;
        addrs[2]   = 32'h40;
        addends[0] = 32'h0000_0011;
        addends[1] = 32'h0000_0222;
        addends[2] = 32'h0000_3300;
        for (int i = 0; i < 3; i++) begin
            drive_inputs(1'b1, addrs[i], 1'b0, '0);
        end
        for (int i = 0; i < 3; i++) begin
            repeat (4) next_cycle();   // Addends trail well behind
            model_op(addrs[i], addends[i]);
            drive_inputs(1'b0, '0, 1'b1, addends[i]);
        end
        wait_results();
        end_test("uneven_rates");
    endtask

    task automatic test_fill_fifos();
        int    pushed;
        logic  filled;
        xlen_t addr;
        test_errors_start = error_count;
        pushed = 0;
        filled = 1'b0;
        while (!filled && pushed < MAX_FILL_PAIRS) begin
            if (uut.slot.input1_fifo.full && uut.slot.input2_fifo.full) begin
                filled = 1'b1;
            end else begin
                addr = pushed[0] ? 32'h24 : 32'h20;
                push_pair(addr, xlen_t'(pushed + 1) * 32'h0101);
                pushed++;
            end
        end
        if (!filled) begin
            $display("Operand FIFOs never filled after %0d back-to-back pairs", pushed);
            error_count++;
        end
        wait_results();
        end_test("fill_fifos");
    endtask

    task automatic test_random_pairs();
        xlen_t r;
        xlen_t addr;
        xlen_t addend;
        int    start_count;
        int    gap;
        test_errors_start = error_count;
        start_count = result_count;
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            r      = $random(seed);
            addr   = (r % `RCA_MEM_WORDS) << 2;
            addend = $random(seed);
            push_pair(addr, addend);
            gap = $random(seed) & 3;
            repeat (gap) next_cycle();
        end
        wait_results();
        repeat (10) next_cycle();   // Room for a stray extra result
        if (result_count - start_count != RANDOM_PAIRS) begin
            $display("[ERROR] %0t result count expected %0d got %0d",
                     $time, RANDOM_PAIRS, result_count - start_count);
            error_count++;
        end
        end_test("random_pairs");
    endtask

    initial begin
        reset          = 1'b1;
        data_in1       = '0;
        data_in2       = '0;
        data_valid_in1 = 1'b0;
        data_valid_in2 = 1'b0;
        for (int i = 0; i < `RCA_MEM_WORDS; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_idle();
        test_single_op();
        test_uneven_rates();
        test_fill_fifos();
        test_random_pairs();
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with results outstanding", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/rca_slot_top.sv
`default_nettype none
`timescale 1ns/100ps

module rca_slot_top (
    input  logic           clk,
    input  logic           reset,
    input  rca_pkg::xlen_t data_in1,
    input  rca_pkg::xlen_t data_in2,
    input  logic           data_valid_in1,
    input  logic           data_valid_in2,
    output rca_pkg::xlen_t data_out,
    output logic           data_valid_out
);

    import rca_pkg::*;

    lsq_req_t  lsq_req;
    lsq_resp_t lsq_resp;
    logic      new_request;
    logic      lsq_full;

    grid_pr_slot slot (
        .clk,
        .reset,
        .data_in1,
        .data_in2,
        .data_valid_in1,
        .data_valid_in2,
        .data_out,
        .data_valid_out,
        .lsq_req,
        .new_request,
        .lsq_full,
        .lsq_resp
    );

    // Stands in for the core's load-store path
    lsq_mem lsq (
        .clk,
        .reset,
        .lsq_req,
        .new_request,
        .lsq_full,
        .lsq_resp
    );

endmodule

`default_nettype wire

//--- source/lsq_mem.sv
`default_nettype none
`timescale 1ns/100ps

`include "rca_macros.svh"

module lsq_mem (
    input  logic               clk,
    input  logic               reset,
    input  rca_pkg::lsq_req_t  lsq_req,
    input  logic               new_request,
    output logic               lsq_full,
    output rca_pkg::lsq_resp_t lsq_resp
);

    import rca_pkg::*;

    localparam int IDX_W = $clog2(`RCA_MEM_WORDS);

    xlen_t mem [`RCA_MEM_WORDS];

    lsq_req_t         head;
    logic             head_valid;
    logic [IDX_W-1:0] head_idx;
    xlen_t            load_data_r;
    logic             load_complete_r;

    // Requests are served strictly in arrival order
    slot_fifo #(.payload_t(lsq_req_t), .DEPTH(`RCA_FIFO_DEPTH)) req_fifo (
        .clk,
        .reset,
        .push      (new_request),
        .push_data (lsq_req),
        .pop       (head_valid),   // One request retires every cycle
        .pop_data  (head),
        .valid     (head_valid),
        .full      (lsq_full)
    );

    assign head_idx = head.addr[IDX_W+1:2];   // Word select, byte offset dropped

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RCA_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (head_valid && head.store) begin
            mem[head_idx] <= head.data;
        end
    end

    // Load answer lands one cycle after the pop
    always_ff @(posedge clk) begin
        if (reset) begin
            load_complete_r <= 1'b0;
        end else begin
            load_complete_r <= head_valid && head.load;
        end
    end

    always_ff @(posedge clk) begin
        if (head_valid && head.load) begin
            load_data_r <= mem[head_idx];
        end
    end

    assign lsq_resp.load_data     = load_data_r;
    assign lsq_resp.load_complete = load_complete_r;

endmodule

`default_nettype wire

//--- source/grid_pr_slot.sv
`default_nettype none
`timescale 1ns/100ps

`include "rca_macros.svh"

module grid_pr_slot (
    input  logic               clk,
    input  logic               reset,

    input  rca_pkg::xlen_t     data_in1,
    input  rca_pkg::xlen_t     data_in2,
    input  logic               data_valid_in1,
    input  logic               data_valid_in2,

    output rca_pkg::xlen_t     data_out,
    output logic               data_valid_out,

    // Load-store queue interface
    output rca_pkg::lsq_req_t  lsq_req,
    output logic               new_request,
    input  logic               lsq_full,
    input  rca_pkg::lsq_resp_t lsq_resp
);

    import rca_pkg::*;

    // The two operand streams run at their own rates, so each gets a queue
    xlen_t input1_head;
    xlen_t input2_head;
    logic  input1_valid;
    logic  input2_valid;
    logic  ou_ack1;
    logic  ou_ack2;

    slot_fifo #(.payload_t(xlen_t), .DEPTH(`RCA_FIFO_DEPTH)) input1_fifo (
        .clk,
        .reset,
        .push      (data_valid_in1),
        .push_data (data_in1),
        .pop       (ou_ack1),
        .pop_data  (input1_head),
        .valid     (input1_valid),
        .full      ()
    );

    slot_fifo #(.payload_t(xlen_t), .DEPTH(`RCA_FIFO_DEPTH)) input2_fifo (
        .clk,
        .reset,
        .push      (data_valid_in2),
        .push_data (data_in2),
        .pop       (ou_ack2),
        .pop_data  (input2_head),
        .valid     (input2_valid),
        .full      ()
    );

    fetch_add_unit ou (
        .clk,
        .reset,
        .data_in1       (input1_head),
        .data_in2       (input2_head),
        .data_valid_in1 (input1_valid),
        .data_valid_in2 (input2_valid),
        .data_in_ack1   (ou_ack1),
        .data_in_ack2   (ou_ack2),
        .data_out,
        .data_valid_out,
        .lsq_req,
        .new_request,
        .lsq_full,
        .lsq_resp
    );

endmodule

`default_nettype wire

//--- source/fetch_add_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "rca_macros.svh"

module fetch_add_unit (
    input  logic               clk,
    input  logic               reset,

    // Heads of the operand FIFOs: address on input 1, addend on input 2
    input  rca_pkg::xlen_t     data_in1,
    input  rca_pkg::xlen_t     data_in2,
    input  logic               data_valid_in1,
    input  logic               data_valid_in2,
    output logic               data_in_ack1,
    output logic               data_in_ack2,

    output rca_pkg::xlen_t     data_out,
    output logic               data_valid_out,

    // LSQ side
    output rca_pkg::lsq_req_t  lsq_req,
    output logic               new_request,
    input  logic               lsq_full,
    input  rca_pkg::lsq_resp_t lsq_resp
);

    import rca_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_LOAD,
        STORE_PENDING
    } state_t;

    state_t state;
    state_t state_next;

    xlen_t addr_r;     // Target address of the operation in flight
    xlen_t addend_r;
    xlen_t sum_r;      // Held while the store waits on a full LSQ
    xlen_t sum;

    logic issue_load;
    logic issue_store;
    logic load_done;

    assign issue_load  = (state == IDLE) && data_valid_in1 && data_valid_in2 && !lsq_full;
    assign load_done   = (state == WAIT_LOAD) && lsq_resp.load_complete;
    assign issue_store = (load_done || (state == STORE_PENDING)) && !lsq_full;

    assign sum = lsq_resp.load_data + addend_r;

    // Both operands leave their FIFOs together
    assign data_in_ack1 = issue_load;
    assign data_in_ack2 = issue_load;

    assign data_out       = sum;
    assign data_valid_out = load_done;

    assign new_request = issue_load || issue_store;

    always_comb begin
        lsq_req.addr  = addr_r;
        lsq_req.data  = (state == STORE_PENDING) ? sum_r : sum;
        lsq_req.fn3   = `RCA_FN3_WORD;
        lsq_req.load  = 1'b0;
        lsq_req.store = 1'b0;
        if (issue_load) begin
            lsq_req.addr = data_in1;   // Address goes out straight from the FIFO head
            lsq_req.data = '0;
            lsq_req.load = 1'b1;
        end else begin
            lsq_req.store = issue_store;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (issue_load) begin
                    state_next = WAIT_LOAD;
                end
            end
            WAIT_LOAD: begin
                if (load_done) begin
                    state_next = issue_store ? IDLE : STORE_PENDING;
                end
            end
            STORE_PENDING: begin
                if (!lsq_full) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_load) begin
            addr_r   <= data_in1;
            addend_r <= data_in2;
        end
        if (load_done) begin
            sum_r <= sum;
        end
    end

endmodule

`default_nettype wire

//--- source/slot_fifo.sv
`default_nettype none
`timescale 1ns/100ps

`include "rca_macros.svh"

module slot_fifo #(
    parameter type payload_t = rca_pkg::xlen_t,
    parameter int  DEPTH     = `RCA_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     valid,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t entries [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;   // Push into a full queue is lost
    assign do_pop  = pop && valid;

    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign pop_data = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves occupancy unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rca_pkg.sv
`default_nettype none

`include "rca_macros.svh"

package rca_pkg;

    typedef logic [`RCA_XLEN-1:0] xlen_t;

    // Request record as seen by the load-store queue
    typedef struct packed {
        xlen_t      addr;
        xlen_t      data;   // Store data, ignored for loads
        logic [2:0] fn3;
        logic       load;
        logic       store;
    } lsq_req_t;

    typedef struct packed {
        xlen_t load_data;
        logic  load_complete;   // One-cycle strobe
    } lsq_resp_t;

endpackage

`default_nettype wire

//--- source/rca_macros.svh
`ifndef RCA_MACROS_SVH
`define RCA_MACROS_SVH

// Data and address width of the grid
`define RCA_XLEN 32

// Entries in every slot FIFO, operand and LSQ request queues alike
`define RCA_FIFO_DEPTH 4

// Word memory behind the LSQ, indexed by address bits 7 to 2
`define RCA_MEM_WORDS 64

// RISC-V funct3 encoding for a 32-bit access
`define RCA_FN3_WORD 3'b010

`endif
